//--- rtl/rv_pkg.sv
/*
 * shared rv32i definitions: widths, opcode and funct codes,
 * alu operation and branch kind enums, ecall register index
 */
package rv_pkg;

    // --------------------------------------------------
    // widths
    // --------------------------------------------------
    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    // ecall reports a0
    localparam logic [REG_AW-1:0] ECALL_REG = 5'd10;

    // --------------------------------------------------
    // opcodes
    // --------------------------------------------------
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    // branch kinds
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [2:0] F3_BLT = 3'b100;
    localparam logic [2:0] F3_BGE = 3'b101;

    // alu kinds, register and immediate forms
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SRL = 3'b101;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    // funct7 that turns add into sub on register ops
    localparam logic [6:0] F7_SUB = 7'b0100000;

    // --------------------------------------------------
    // enums
    // --------------------------------------------------
    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, SLT, SLL, SRL, PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        NONE, BEQ, BNE, BLT, BGE, JAL
    } br_kind_e;

endpackage

//--- rtl/pipe_if.sv
/*
 * pipeline interfaces: decode to execute, and execute to the
 * result stage with the forward path coming back
 */
`timescale 1ns/1ns

interface dec_exe_if #(
    parameter int PC_W = 10
);
    logic                        valid;
    logic [PC_W-1:0]             pc;
    logic [rv_pkg::REG_AW-1:0]   rd;
    logic [rv_pkg::REG_AW-1:0]   rs1;
    logic [rv_pkg::REG_AW-1:0]   rs2;
    logic [rv_pkg::XLEN-1:0]     imm;
    logic                        use_imm;
    rv_pkg::alu_op_e             alu_op;
    rv_pkg::br_kind_e            br_kind;
    logic                        reg_write;
    logic                        ecall;

    modport dec (
        output valid, pc, rd, rs1, rs2, imm, use_imm, alu_op, br_kind, reg_write, ecall
    );
    modport exe (
        input valid, pc, rd, rs1, rs2, imm, use_imm, alu_op, br_kind, reg_write, ecall
    );
endinterface

interface exe_res_if;
    logic                        valid;
    logic [rv_pkg::REG_AW-1:0]   rd;
    logic [rv_pkg::XLEN-1:0]     data;
    logic                        reg_write;
    logic                        ecall;

    // forward source, driven by the result stage
    logic                        fwd_valid;
    logic [rv_pkg::REG_AW-1:0]   fwd_rd;
    logic [rv_pkg::XLEN-1:0]     fwd_data;

    modport exe (output valid, rd, data, reg_write, ecall,
                 input  fwd_valid, fwd_rd, fwd_data);
    modport res (input  valid, rd, data, reg_write, ecall,
                 output fwd_valid, fwd_rd, fwd_data);
endinterface

//--- rtl/inst_decode.sv
/*
 * run control FSM, program counter, instruction decoder and
 * the decode to execute pipeline register
 */
`timescale 1ns/1ns

module inst_decode #(
    parameter int PC_W = 10
) (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_start,
    input  logic [rv_pkg::XLEN-1:0] i_inst,
    input  logic                    i_redirect,
    input  logic [PC_W-1:0]         i_target,
    input  logic                    i_halt,
    output logic [PC_W-1:0]         o_pc,
    dec_exe_if.dec                  dec_exe
);

    typedef enum logic [1:0] {IDLE, RUN, HALT} state_e;

    state_e state, state_nxt;

    // instruction fields
    logic [6:0]                opcode;
    logic [2:0]                funct3;
    logic [6:0]                funct7;
    logic [rv_pkg::XLEN-1:0]   imm_i, imm_u, imm_b, imm_j;

    // decoded controls
    logic [rv_pkg::XLEN-1:0]   imm;
    logic [rv_pkg::REG_AW-1:0] rs1;
    logic                      use_imm;
    logic                      reg_write;
    logic                      ecall;
    rv_pkg::alu_op_e           alu_op;
    rv_pkg::br_kind_e          br_kind;

    // --------------------------------------------------
    // run control and program counter
    // --------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (i_start) state_nxt = RUN;
            end
            RUN: begin
                if (i_halt) state_nxt = HALT;
            end
            default: state_nxt = state;     // HALT holds until reset
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= IDLE;
            o_pc  <= '0;
        end else begin
            state <= state_nxt;
            if (state == RUN && !i_halt) begin
                // word index, branch targets already shifted
                o_pc <= i_redirect ? i_target : o_pc + 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // decoder
    // --------------------------------------------------
    assign opcode = i_inst[6:0];
    assign funct3 = i_inst[14:12];
    assign funct7 = i_inst[31:25];

    assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
    assign imm_u = {i_inst[31:12], 12'd0};
    assign imm_b = {{20{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
    assign imm_j = {{12{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

    always_comb begin
        imm       = imm_i;
        rs1       = i_inst[19:15];
        use_imm   = 1'b0;
        reg_write = 1'b0;
        ecall     = 1'b0;
        br_kind   = rv_pkg::NONE;
        case (funct3)
            rv_pkg::F3_SLL: alu_op = rv_pkg::SLL;
            rv_pkg::F3_SLT: alu_op = rv_pkg::SLT;
            rv_pkg::F3_XOR: alu_op = rv_pkg::XOR;
            rv_pkg::F3_SRL: alu_op = rv_pkg::SRL;
            rv_pkg::F3_OR:  alu_op = rv_pkg::OR;
            rv_pkg::F3_AND: alu_op = rv_pkg::AND;
            default:        alu_op = rv_pkg::ADD;
        endcase

        case (opcode)
            rv_pkg::OP_REG: begin
                reg_write = 1'b1;
                if (funct3 == rv_pkg::F3_ADD && funct7 == rv_pkg::F7_SUB) alu_op = rv_pkg::SUB;
            end
            rv_pkg::OP_IMM: begin
                use_imm   = 1'b1;
                reg_write = 1'b1;
            end
            rv_pkg::OP_LUI: begin
                imm       = imm_u;
                use_imm   = 1'b1;
                reg_write = 1'b1;
                alu_op    = rv_pkg::PASS_B;
            end
            rv_pkg::OP_BRANCH: begin
                imm = imm_b;
                case (funct3)
                    rv_pkg::F3_BEQ: br_kind = rv_pkg::BEQ;
                    rv_pkg::F3_BNE: br_kind = rv_pkg::BNE;
                    rv_pkg::F3_BLT: br_kind = rv_pkg::BLT;
                    rv_pkg::F3_BGE: br_kind = rv_pkg::BGE;
                    default:        br_kind = rv_pkg::NONE;
                endcase
            end
            rv_pkg::OP_JAL: begin
                imm       = imm_j;
                reg_write = 1'b1;
                br_kind   = rv_pkg::JAL;
            end
            rv_pkg::OP_SYSTEM: begin
                // ecall reads a0 through the rs1 port
                ecall = (funct3 == 3'd0) && (i_inst[31:20] == 12'd0);
                rs1   = rv_pkg::ECALL_REG;
            end
            default: ;
        endcase
    end

    // --------------------------------------------------
    // decode to execute register
    // --------------------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            dec_exe.valid <= 1'b0;
        end else begin
            // flush on taken branch, jal or ecall
            dec_exe.valid <= (state == RUN) && !i_redirect && !i_halt;
        end
    end

    always_ff @(posedge i_clk) begin
        dec_exe.pc        <= o_pc;
        dec_exe.rd        <= i_inst[11:7];
        dec_exe.rs1       <= rs1;
        dec_exe.rs2       <= i_inst[24:20];
        dec_exe.imm       <= imm;
        dec_exe.use_imm   <= use_imm;
        dec_exe.alu_op    <= alu_op;
        dec_exe.br_kind   <= br_kind;
        dec_exe.reg_write <= reg_write;
        dec_exe.ecall     <= ecall;
    end

endmodule

//--- rtl/reg_file.sv
/*
 * 32 entry integer register file, two reads and one write
 */
`timescale 1ns/1ns

module reg_file (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  logic                      i_we,
    input  logic [rv_pkg::REG_AW-1:0] i_waddr,
    input  logic [rv_pkg::XLEN-1:0]   i_wdata,
    input  logic [rv_pkg::REG_AW-1:0] i_raddr1,
    input  logic [rv_pkg::REG_AW-1:0] i_raddr2,
    output logic [rv_pkg::XLEN-1:0]   o_rdata1,
    output logic [rv_pkg::XLEN-1:0]   o_rdata2
);

    localparam int NREG = 2 ** rv_pkg::REG_AW;

    logic [rv_pkg::XLEN-1:0] regs [NREG];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < NREG; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && i_waddr != '0) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    // x0 reads zero
    assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
    assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

//--- rtl/execute.sv
/*
 * execute stage: operand select with forwarding, alu,
 * branch compare, jal link value and redirect, ecall halt
 */
`timescale 1ns/1ns

module execute #(
    parameter int PC_W = 10
) (
    dec_exe_if.exe                    dec_exe,
    exe_res_if.exe                    exe_res,
    output logic [rv_pkg::REG_AW-1:0] o_raddr1,
    output logic [rv_pkg::REG_AW-1:0] o_raddr2,
    input  logic [rv_pkg::XLEN-1:0]   i_rdata1,
    input  logic [rv_pkg::XLEN-1:0]   i_rdata2,
    output logic                      o_redirect,
    output logic [PC_W-1:0]           o_target,
    output logic                      o_halt
);

    localparam int XLEN    = rv_pkg::XLEN;
    localparam int SHAMT_W = $clog2(XLEN);

    logic            fwd_a, fwd_b;
    logic [XLEN-1:0] op_a, rs2_val, op_b;
    logic [XLEN-1:0] alu_res, link;
    logic [PC_W-1:0] pc_inc;
    logic            eq, lt, taken;

    // --------------------------------------------------
    // operands
    // --------------------------------------------------
    assign o_raddr1 = dec_exe.rs1;
    assign o_raddr2 = dec_exe.rs2;

    // result register is the only forward source
    assign fwd_a = exe_res.fwd_valid && (exe_res.fwd_rd == dec_exe.rs1)
                   && (dec_exe.rs1 != '0);
    assign fwd_b = exe_res.fwd_valid && (exe_res.fwd_rd == dec_exe.rs2)
                   && (dec_exe.rs2 != '0);

    assign op_a    = fwd_a ? exe_res.fwd_data : i_rdata1;
    assign rs2_val = fwd_b ? exe_res.fwd_data : i_rdata2;
    assign op_b    = dec_exe.use_imm ? dec_exe.imm : rs2_val;

    // --------------------------------------------------
    // alu
    // --------------------------------------------------
    always_comb begin
        case (dec_exe.alu_op)
            rv_pkg::ADD:    alu_res = op_a + op_b;
            rv_pkg::SUB:    alu_res = op_a - op_b;
            rv_pkg::AND:    alu_res = op_a & op_b;
            rv_pkg::OR:     alu_res = op_a | op_b;
            rv_pkg::XOR:    alu_res = op_a ^ op_b;
            rv_pkg::SLT:    alu_res = {{(XLEN-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
            rv_pkg::SLL:    alu_res = op_a << op_b[SHAMT_W-1:0];
            rv_pkg::SRL:    alu_res = op_a >> op_b[SHAMT_W-1:0];
            rv_pkg::PASS_B: alu_res = op_b;
            default:        alu_res = op_a + op_b;
        endcase
    end

    // --------------------------------------------------
    // branches and jal
    // --------------------------------------------------
    assign eq = (op_a == rs2_val);
    assign lt = ($signed(op_a) < $signed(rs2_val));

    always_comb begin
        case (dec_exe.br_kind)
            rv_pkg::BEQ: taken = eq;
            rv_pkg::BNE: taken = !eq;
            rv_pkg::BLT: taken = lt;
            rv_pkg::BGE: taken = !lt;
            rv_pkg::JAL: taken = 1'b1;
            default:     taken = 1'b0;
        endcase
    end

    // pc is a word index, so the byte offset drops its low two bits
    assign o_target   = dec_exe.pc + dec_exe.imm[PC_W+1:2];
    assign o_redirect = dec_exe.valid && taken;
    assign o_halt     = dec_exe.valid && dec_exe.ecall;

    // link is the byte address of the next instruction
    assign pc_inc = dec_exe.pc + 1'b1;
    assign link   = {{(XLEN-PC_W-2){1'b0}}, pc_inc, 2'b00};

    // --------------------------------------------------
    // to result stage
    // --------------------------------------------------
    assign exe_res.valid     = dec_exe.valid;
    assign exe_res.rd        = dec_exe.rd;
    assign exe_res.reg_write = dec_exe.reg_write;
    assign exe_res.ecall     = dec_exe.ecall;

    always_comb begin
        if (dec_exe.ecall) begin
            exe_res.data = op_a;    // a0, forwarded if needed
        end else if (dec_exe.br_kind == rv_pkg::JAL) begin
            exe_res.data = link;
        end else begin
            exe_res.data = alu_res;
        end
    end

endmodule

//--- rtl/result_stage.sv
/*
 * result register: register file write, forward source and
 * the registered ecall report
 */
`timescale 1ns/1ns

module result_stage (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    exe_res_if.res                    exe_res,
    output logic                      o_we,
    output logic [rv_pkg::REG_AW-1:0] o_waddr,
    output logic [rv_pkg::XLEN-1:0]   o_wdata,
    output logic                      o_ecall_valid,
    output logic [rv_pkg::XLEN-1:0]   o_ecall_data
);

    logic                      res_valid;
    logic                      res_reg_write;
    logic [rv_pkg::REG_AW-1:0] res_rd;
    logic [rv_pkg::XLEN-1:0]   res_data;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            res_valid     <= 1'b0;
            o_ecall_valid <= 1'b0;
        end else begin
            res_valid     <= exe_res.valid;
            // one cycle, execute is flushed behind the ecall
            o_ecall_valid <= exe_res.valid && exe_res.ecall;
        end
    end

    always_ff @(posedge i_clk) begin
        res_rd        <= exe_res.rd;
        res_data      <= exe_res.data;
        res_reg_write <= exe_res.reg_write;
        if (exe_res.valid && exe_res.ecall) begin
            o_ecall_data <= exe_res.data;
        end
    end

    // write port, written at the end of this cycle
    assign o_we    = res_valid && res_reg_write;
    assign o_waddr = res_rd;
    assign o_wdata = res_data;

    // forward source back to execute
    assign exe_res.fwd_valid = o_we;
    assign exe_res.fwd_rd    = res_rd;
    assign exe_res.fwd_data  = res_data;

endmodule

//--- rtl/cpu_top.sv
/*
 * rv32i core top level: decode, register file, execute and
 * result stage joined by the pipeline interfaces
 */
`timescale 1ns/1ns

module cpu_top #(
    parameter int PC_W = 10
) (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_start,
    input  logic [rv_pkg::XLEN-1:0] i_inst,
    output logic [PC_W-1:0]         o_pc,
    output logic                    o_ecall_valid,
    output logic [rv_pkg::XLEN-1:0] o_ecall_data
);

    // redirect path from execute
    logic                      redirect;
    logic [PC_W-1:0]           target;
    logic                      halt;

    // register file ports
    logic [rv_pkg::REG_AW-1:0] raddr1, raddr2, waddr;
    logic [rv_pkg::XLEN-1:0]   rdata1, rdata2, wdata;
    logic                      we;

    dec_exe_if #(.PC_W(PC_W)) u_dec_exe ();
    exe_res_if                u_exe_res ();

    inst_decode #(.PC_W(PC_W)) u_inst_decode (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_start    (i_start),
        .i_inst     (i_inst),
        .i_redirect (redirect),
        .i_target   (target),
        .i_halt     (halt),
        .o_pc       (o_pc),
        .dec_exe    (u_dec_exe.dec)
    );

    reg_file u_reg_file (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_we     (we),
        .i_waddr  (waddr),
        .i_wdata  (wdata),
        .i_raddr1 (raddr1),
        .i_raddr2 (raddr2),
        .o_rdata1 (rdata1),
        .o_rdata2 (rdata2)
    );

    execute #(.PC_W(PC_W)) u_execute (
        .dec_exe    (u_dec_exe.exe),
        .exe_res    (u_exe_res.exe),
        .o_raddr1   (raddr1),
        .o_raddr2   (raddr2),
        .i_rdata1   (rdata1),
        .i_rdata2   (rdata2),
        .o_redirect (redirect),
        .o_target   (target),
        .o_halt     (halt)
    );

    result_stage u_result_stage (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .exe_res       (u_exe_res.res),
        .o_we          (we),
        .o_waddr       (waddr),
        .o_wdata       (wdata),
        .o_ecall_valid (o_ecall_valid),
        .o_ecall_data  (o_ecall_data)
    );

endmodule

//--- verification/cpu_tb.sv
/*
 * testbench for cpu_top with clock, reset, program memory, isa model,
 * directed and random programs, assertions, watchdog and summary
 */
`timescale 1ns/1ns

module cpu_tb;

    localparam int          PC_W     = 10;
    localparam int          CLK_NS   = 10;
    localparam int          N_RAND   = 20;
    localparam int          N_PROG   = N_RAND + 2;  // chain and branch programs plus the random ones
    localparam int          PROG_CYC = 200;
    localparam logic [31:0] NOP      = 32'h0000_0013;
    localparam logic [31:0] ECALL    = 32'h0000_0073;

    logic            clk;
    logic            rst_n;
    logic            start;
    logic [31:0]     inst;
    logic [PC_W-1:0] pc;
    logic            ecall_valid;
    logic [31:0]     ecall_data;

    logic [31:0]     prog [2**PC_W];
    logic [PC_W-1:0] prog_len;
    logic [31:0]     exp_a0;
    logic            started;
    logic            halted;
    logic [PC_W-1:0] pc_q;
    int              pulse_cnt;
    int              err_cnt;
    int              seed;

    cpu_top #(.PC_W(PC_W)) u_cpu_top (
        .i_clk         (clk),
        .i_rst_n       (rst_n),
        .i_start       (start),
        .i_inst        (inst),
        .o_pc          (pc),
        .o_ecall_valid (ecall_valid),
        .o_ecall_data  (ecall_data)
    );

    initial clk = 1'b0;
    always #(CLK_NS / 2) clk = ~clk;

    // fetch by word index with nop past the end of the program
    always @(negedge clk) begin
        inst <= (pc < prog_len) ? prog[pc] : NOP;
    end

    // history for the halt checks
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            halted    <= 1'b0;
            pulse_cnt <= 0;
            pc_q      <= '0;
        end else begin
            pc_q <= pc;
            if (ecall_valid) begin
                halted    <= 1'b1;
                pulse_cnt <= pulse_cnt + 1;
            end
        end
    end

    // --------------------------------------------------
    // assertions
    // --------------------------------------------------
    idle_pc_chk: assert property (@(posedge clk) disable iff (!rst_n)
        !started |-> pc == '0)
    else begin
        err_cnt = err_cnt + 1;
        $display("FAIL o_pc: got %h, expected %h", $sampled(pc), {PC_W{1'b0}});
    end

    idle_ecall_chk: assert property (@(posedge clk) disable iff (!rst_n)
        !started |-> !ecall_valid)
    else begin
        err_cnt = err_cnt + 1;
        $display("FAIL o_ecall_valid: got %h, expected %h", $sampled(ecall_valid), 1'b0);
    end

    data_chk: assert property (@(posedge clk) disable iff (!rst_n)
        ecall_valid |-> ecall_data == exp_a0)
    else begin
        err_cnt = err_cnt + 1;
        $display("FAIL o_ecall_data: got %h, expected %h", $sampled(ecall_data),
                 $sampled(exp_a0));
    end

    // catches any pulse after the first one whether adjacent or later
    pulse_chk: assert property (@(posedge clk) disable iff (!rst_n)
        ecall_valid |-> pulse_cnt == 0)
    else begin
        err_cnt = err_cnt + 1;
        $display("o_ecall_valid was high again after the ecall report");
    end

    freeze_chk: assert property (@(posedge clk) disable iff (!rst_n)
        (halted || ecall_valid) |-> pc == pc_q)
    else begin
        err_cnt = err_cnt + 1;
        $display("FAIL o_pc: got %h, expected %h", $sampled(pc), $sampled(pc_q));
    end

    // --------------------------------------------------
    // instruction encoders
    // --------------------------------------------------
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rv_pkg::OP_REG};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, rv_pkg::OP_IMM};
    endfunction

    function automatic logic [31:0] addi_inst(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [11:0] imm);
        return i_type(imm, rs1, rv_pkg::F3_ADD, rd);
    endfunction

    function automatic logic [31:0] lui_inst(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, rv_pkg::OP_LUI};
    endfunction

    // offsets given in words and encoded in bytes
    function automatic logic [31:0] branch_inst(input logic [2:0] f3, input logic [4:0] rs1,
                                                input logic [4:0] rs2, input int words);
        logic [12:0] off;
        off = 13'(words * 4);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_pkg::OP_BRANCH};
    endfunction

    function automatic logic [31:0] jal_inst(input logic [4:0] rd, input int words);
        logic [20:0] off;
        off = 21'(words * 4);
        return {off[20], off[10:1], off[11], off[19:12], rd, rv_pkg::OP_JAL};
    endfunction

    function automatic logic [31:0] random_inst(input logic [31:0] r, input logic [31:0] s);
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        rd  = r[0] ? 5'd10 : {1'b0, r[4:1]};
        rs1 = {1'b0, r[8:5]};
        rs2 = {1'b0, r[12:9]};
        f3  = (r[15:13] == 3'b011) ? rv_pkg::F3_ADD : r[15:13];
        // shifts take a 5 bit amount
        imm = (f3 == rv_pkg::F3_SLL || f3 == rv_pkg::F3_SRL) ? {7'd0, s[4:0]} : s[11:0];
        case (r[17:16])
            2'd0:    return lui_inst(s[31:12], rd);
            2'd1:    return r_type((f3 == rv_pkg::F3_ADD && r[18]) ? rv_pkg::F7_SUB : 7'd0,
                                   rs2, rs1, f3, rd);
            default: return i_type(imm, rs1, f3, rd);
        endcase
    endfunction

    // --------------------------------------------------
    // isa reference model
    // --------------------------------------------------
    function automatic logic [31:0] isa_alu(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'd0, $signed(a) < $signed(b)};
            3'b100:  return a ^ b;
            3'b101:  return a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            default: return 1'b0;
        endcase
    endfunction

    // runs the loaded program and returns a0 at its ecall
    function automatic logic [31:0] reference_a0();
        logic [31:0]     x [32];
        logic [31:0]     ins;
        logic [31:0]     a;
        logic [31:0]     b;
        logic [31:0]     res;
        logic [31:0]     imm_b;
        logic [31:0]     imm_j;
        logic [PC_W-1:0] pc_m;
        logic            wr;
        x    = '{default: '0};
        pc_m = '0;
        for (int step = 0; step < PROG_CYC; step++) begin
            ins   = (pc_m < prog_len) ? prog[pc_m] : NOP;
            a     = x[ins[19:15]];
            b     = x[ins[24:20]];
            imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            wr    = 1'b1;
            res   = '0;
            case (ins[6:0])
                rv_pkg::OP_SYSTEM: return x[10];
                rv_pkg::OP_LUI:    res = {ins[31:12], 12'd0};
                rv_pkg::OP_IMM:    res = isa_alu(ins[14:12], 1'b0, a,
                                                 {{20{ins[31]}}, ins[31:20]});
                rv_pkg::OP_REG:    res = isa_alu(ins[14:12], ins[30], a, b);
                rv_pkg::OP_JAL:    res = 32'd4 * (32'(pc_m) + 32'd1);
                default:           wr = 1'b0;
            endcase
            if (wr && ins[11:7] != 5'd0) begin
                x[ins[11:7]] = res;
            end
            if (ins[6:0] == rv_pkg::OP_JAL) begin
                pc_m = pc_m + PC_W'($signed(imm_j) >>> 2);
            end else if (ins[6:0] == rv_pkg::OP_BRANCH && branch_taken(ins[14:12], a, b)) begin
                pc_m = pc_m + PC_W'($signed(imm_b) >>> 2);
            end else begin
                pc_m = pc_m + 1'b1;
            end
        end
        return 32'hdead_beef;
    endfunction

    // --------------------------------------------------
    // programs
    // --------------------------------------------------
    task automatic append_inst(input logic [31:0] ins);
        prog[prog_len] = ins;
        prog_len       = prog_len + 1'b1;
    endtask

    // would change a0 if not flushed
    task automatic shadow_pair();
        append_inst(addi_inst(5'd10, 5'd10, 12'd100));
        append_inst(addi_inst(5'd10, 5'd10, 12'd200));
    endtask

    task automatic chain_program();
        prog_len = '0;
        append_inst(lui_inst(20'h12345, 5'd5));
        append_inst(i_type(12'h678, 5'd5, rv_pkg::F3_ADD, 5'd5));
        append_inst(i_type(12'hfff, 5'd5, rv_pkg::F3_XOR, 5'd6));
        append_inst(r_type(7'd0, 5'd6, 5'd5, rv_pkg::F3_ADD, 5'd7));
        append_inst(r_type(rv_pkg::F7_SUB, 5'd5, 5'd7, rv_pkg::F3_ADD, 5'd8));
        append_inst(i_type(12'd4, 5'd8, rv_pkg::F3_SLL, 5'd9));
        append_inst(i_type(12'd3, 5'd9, rv_pkg::F3_SRL, 5'd10));
        append_inst(r_type(7'd0, 5'd5, 5'd10, rv_pkg::F3_OR, 5'd10));
        append_inst(r_type(7'd0, 5'd7, 5'd10, rv_pkg::F3_AND, 5'd11));
        append_inst(r_type(7'd0, 5'd5, 5'd8, rv_pkg::F3_SLT, 5'd12));
        append_inst(i_type(12'd1, 5'd12, rv_pkg::F3_SLT, 5'd13));
        append_inst(r_type(7'd0, 5'd13, 5'd10, rv_pkg::F3_SLL, 5'd14));
        append_inst(r_type(7'd0, 5'd12, 5'd14, rv_pkg::F3_SRL, 5'd15));
        append_inst(r_type(7'd0, 5'd11, 5'd15, rv_pkg::F3_XOR, 5'd10));
        append_inst(i_type(12'h7f0, 5'd10, rv_pkg::F3_AND, 5'd16));
        append_inst(lui_inst(20'h80000, 5'd17));
        append_inst(r_type(7'd0, 5'd16, 5'd10, rv_pkg::F3_ADD, 5'd10));
        append_inst(r_type(7'd0, 5'd17, 5'd10, rv_pkg::F3_OR, 5'd10));
        append_inst(ECALL);
    endtask

    task automatic branch_program();
        prog_len = '0;
        append_inst(addi_inst(5'd1, 5'd0, 12'd5));
        append_inst(addi_inst(5'd2, 5'd0, 12'hffd));
        append_inst(addi_inst(5'd10, 5'd0, 12'd0));
        append_inst(branch_inst(rv_pkg::F3_BEQ, 5'd1, 5'd1, 3));
        shadow_pair();
        append_inst(branch_inst(rv_pkg::F3_BNE, 5'd1, 5'd1, 2));
        append_inst(addi_inst(5'd10, 5'd10, 12'd1));
        append_inst(branch_inst(rv_pkg::F3_BNE, 5'd1, 5'd2, 3));
        shadow_pair();
        append_inst(branch_inst(rv_pkg::F3_BEQ, 5'd1, 5'd2, 2));
        append_inst(addi_inst(5'd10, 5'd10, 12'd2));
        append_inst(branch_inst(rv_pkg::F3_BLT, 5'd2, 5'd1, 3));
        shadow_pair();
        append_inst(branch_inst(rv_pkg::F3_BLT, 5'd1, 5'd2, 2));
        append_inst(addi_inst(5'd10, 5'd10, 12'd4));
        append_inst(branch_inst(rv_pkg::F3_BGE, 5'd1, 5'd2, 3));
        shadow_pair();
        append_inst(branch_inst(rv_pkg::F3_BGE, 5'd2, 5'd1, 2));
        append_inst(addi_inst(5'd10, 5'd10, 12'd8));
        // short backward loop of three passes
        append_inst(addi_inst(5'd3, 5'd0, 12'd3));
        append_inst(addi_inst(5'd10, 5'd10, 12'd16));
        append_inst(addi_inst(5'd3, 5'd3, 12'hfff));
        append_inst(branch_inst(rv_pkg::F3_BNE, 5'd3, 5'd0, -2));
        append_inst(jal_inst(5'd11, 3));
        shadow_pair();
        append_inst(r_type(7'd0, 5'd11, 5'd10, rv_pkg::F3_ADD, 5'd10));
        append_inst(ECALL);
    endtask

    task automatic random_program();
        prog_len = '0;
        for (int i = 0; i < 24; i++) begin
            append_inst(random_inst($random(seed), $random(seed)));
        end
        append_inst(ECALL);
    endtask

    // --------------------------------------------------
    // run control
    // --------------------------------------------------
    task automatic reset_dut();
        @(negedge clk);
        rst_n   = 1'b0;
        start   = 1'b0;
        started = 1'b0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
    endtask

    task automatic run_program();
        exp_a0 = reference_a0();
        reset_dut();
        repeat (2) @(negedge clk);
        start   = 1'b1;
        started = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (!ecall_valid) begin
            @(negedge clk);
        end
        // hold in halt so the freeze and pulse checks see it
        repeat (10) @(negedge clk);
    endtask

    initial begin
        seed     = 32'hcf85_aa5a;
        err_cnt  = 0;
        rst_n    = 1'b0;
        start    = 1'b0;
        started  = 1'b0;
        inst     = NOP;
        exp_a0   = '0;
        prog_len = '0;

        // idle after reset with no start
        reset_dut();
        repeat (20) @(negedge clk);

        chain_program();
        run_program();
        branch_program();
        run_program();
        repeat (N_RAND) begin
            random_program();
            run_program();
        end

        $display("programs: %0d, errors: %0d", N_PROG, err_cnt);
        if (err_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(N_PROG * PROG_CYC * CLK_NS);
        err_cnt = err_cnt + 1;
        $display("timeout: a program never reached its ecall report");
        $display("programs: %0d, errors: %0d", N_PROG, err_cnt);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- flist.f
rtl/rv_pkg.sv
rtl/pipe_if.sv
rtl/inst_decode.sv
rtl/reg_file.sv
rtl/execute.sv
rtl/result_stage.sv
rtl/cpu_top.sv
verification/cpu_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the cpu testbench with verilator, run it, look for the pass line
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -j 0 --top-module cpu_tb -f flist.f -o cpu_sim; then
    echo "verilator build failed"
    exit 1
fi

out="$(./obj_dir/cpu_sim)"
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "PASS: all tests"; then
    exit 0
else
    exit 1
fi
